/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Instruction field widths
    localparam int OpcodeWidth = 6;
    localparam int FunctWidth  = 6;

    // Opcodes handled by the control unit
    // Every other value is treated as unknown and returns to fetch
    typedef enum logic [OpcodeWidth-1:0] {
        RType   = 6'h00,  // ALU op selected by funct
        Addi    = 6'h08,
        ResetOp = 6'h3f   // Halts the machine
    } opcodeT;

    // R-type funct field
    typedef enum logic [FunctWidth-1:0] {
        FnAdd = 6'h20,
        FnSub = 6'h22,
        FnAnd = 6'h24
    } functT;

endpackage

`default_nettype wire

/* rtl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // Sequencer phases
    typedef enum logic [3:0] {
        FetchWait,   // Memory read in flight
        FetchLatch,  // PC and IR load
        RegRead,
        Decode,
        ExecAlu,
        ExecWrite,
        ExecDone,
        ResetHold,
        Halted
    } phaseT;

    // Operation captured at decode
    typedef enum logic [2:0] {
        OpNone,
        OpAdd,
        OpAnd,
        OpSub,
        OpAddi
    } opT;

    typedef enum logic [2:0] {
        AluNop = 3'd0,
        AluAdd = 3'd1,
        AluSub = 3'd2,
        AluAnd = 3'd3
    } aluOpT;

    // ALU operand A mux
    typedef enum logic [1:0] {
        SrcAPc  = 2'd0,
        SrcAReg = 2'd1
    } srcAT;

    // ALU operand B mux
    typedef enum logic [1:0] {
        SrcBReg  = 2'd0,
        SrcBFour = 2'd1,  // PC increment
        SrcBImm  = 2'd2
    } srcBT;

    // Register file write address
    typedef enum logic [1:0] {
        DstRt = 2'd0,
        DstRd = 2'd1
    } regDstT;

    function automatic aluOpT aluOpOf(opT op);
        case (op)
            OpAdd, OpAddi: return AluAdd;
            OpSub:         return AluSub;
            OpAnd:         return AluAnd;
            default:       return AluNop;
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic           clk,
    input  logic           reset,
    input  isaPkg::opcodeT opcode,
    input  isaPkg::functT  funct,
    input  ctrlPkg::phaseT phase,
    output ctrlPkg::opT    op,
    output logic           halt
);

    ctrlPkg::opT nextOp;
    ctrlPkg::opT opReg;

    // Opcode and funct to operation
    always_comb begin
        nextOp = ctrlPkg::OpNone;
        case (opcode)
            isaPkg::RType: begin
                case (funct)
                    isaPkg::FnAdd: nextOp = ctrlPkg::OpAdd;
                    isaPkg::FnAnd: nextOp = ctrlPkg::OpAnd;
                    isaPkg::FnSub: nextOp = ctrlPkg::OpSub;
                    default:       nextOp = ctrlPkg::OpNone;  // Unknown funct
                endcase
            end
            isaPkg::Addi: nextOp = ctrlPkg::OpAddi;
            default:      nextOp = ctrlPkg::OpNone;
        endcase
    end

    assign halt = (opcode == isaPkg::ResetOp);

    // Held through execute
    always_ff @(posedge clk) begin
        if (reset) begin
            opReg <= ctrlPkg::OpNone;
        end else if (phase == ctrlPkg::Decode) begin
            opReg <= nextOp;
        end
    end

    // Sequencer branches on the live value during Decode
    assign op = (phase == ctrlPkg::Decode) ? nextOp : opReg;

    // Operation seen by the sequencer only moves in Decode
    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && phase != ctrlPkg::Decode |-> $stable(op))
    else $error("instrDecoder: op changed outside Decode");

endmodule

`default_nettype wire

/* rtl/phaseSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer #(
    parameter int MemWaitCycles = 3
) (
    input  logic           clk,
    input  logic           reset,
    input  ctrlPkg::opT    op,
    input  logic           halt,
    output ctrlPkg::phaseT phase,
    output logic           resetOut
);

    localparam int CntWidth = (MemWaitCycles > 1) ? $clog2(MemWaitCycles) : 1;
    localparam logic [CntWidth-1:0] LastWait = CntWidth'(MemWaitCycles - 1);

    ctrlPkg::phaseT      nextPhase;
    logic [CntWidth-1:0] waitCnt;

    always_comb begin
        nextPhase = phase;
        case (phase)
            ctrlPkg::FetchWait: begin
                if (waitCnt == LastWait) begin
                    nextPhase = ctrlPkg::FetchLatch;
                end
            end
            ctrlPkg::FetchLatch: nextPhase = ctrlPkg::RegRead;
            ctrlPkg::RegRead:    nextPhase = ctrlPkg::Decode;
            ctrlPkg::Decode: begin
                if (halt) begin
                    nextPhase = ctrlPkg::Halted;
                end else if (op != ctrlPkg::OpNone) begin
                    nextPhase = ctrlPkg::ExecAlu;
                end else begin
                    nextPhase = ctrlPkg::FetchWait;  // Unknown code returns without a write
                end
            end
            ctrlPkg::ExecAlu:   nextPhase = ctrlPkg::ExecWrite;
            ctrlPkg::ExecWrite: nextPhase = ctrlPkg::ExecDone;
            ctrlPkg::ExecDone:  nextPhase = ctrlPkg::FetchWait;
            ctrlPkg::ResetHold: nextPhase = ctrlPkg::ResetHold;  // Left only through reset
            ctrlPkg::Halted:    nextPhase = ctrlPkg::Halted;
            default:            nextPhase = ctrlPkg::FetchWait;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            waitCnt <= '0;
            // First reset cycle holds and the second releases into fetch
            if (phase == ctrlPkg::ResetHold) begin
                phase    <= ctrlPkg::FetchWait;
                resetOut <= 1'b0;
            end else begin
                phase    <= ctrlPkg::ResetHold;
                resetOut <= 1'b1;
            end
        end else begin
            phase    <= nextPhase;
            resetOut <= (nextPhase == ctrlPkg::ResetHold) || (nextPhase == ctrlPkg::Halted);
            if (phase == ctrlPkg::FetchWait && waitCnt != LastWait) begin
                waitCnt <= waitCnt + 1'b1;
            end else begin
                waitCnt <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) waitCnt <= LastWait)
    else $error("phaseSequencer: wait counter out of range");

    assert property (@(posedge clk) disable iff (reset)
        resetOut |-> phase inside {ctrlPkg::ResetHold, ctrlPkg::Halted})
    else $error("phaseSequencer: resetOut high outside ResetHold/Halted");

endmodule

`default_nettype wire

/* rtl/controlEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

module controlEncoder (
    input  logic             clk,
    input  logic             reset,
    input  ctrlPkg::phaseT   phase,
    input  ctrlPkg::opT      op,
    output logic             pcWrite,
    output logic             irWrite,
    output logic             regWrite,
    output logic             abWrite,
    output logic             aluOutWrite,
    output ctrlPkg::aluOpT   aluCtrl,
    output ctrlPkg::srcAT    srcA,
    output ctrlPkg::srcBT    srcB,
    output ctrlPkg::regDstT  regDst
);

    logic            nextPcWrite;
    logic            nextIrWrite;
    logic            nextRegWrite;
    logic            nextAbWrite;
    logic            nextAluOutWrite;
    ctrlPkg::aluOpT  nextAluCtrl;
    ctrlPkg::srcAT   nextSrcA;
    ctrlPkg::srcBT   nextSrcB;
    ctrlPkg::regDstT nextRegDst;
    logic            isAddi;

    assign isAddi = (op == ctrlPkg::OpAddi);

    always_comb begin
        nextPcWrite     = 1'b0;
        nextIrWrite     = 1'b0;
        nextRegWrite    = 1'b0;
        nextAbWrite     = 1'b0;
        nextAluOutWrite = 1'b0;
        nextAluCtrl     = ctrlPkg::AluNop;
        nextSrcA        = ctrlPkg::SrcAPc;
        nextSrcB        = ctrlPkg::SrcBReg;
        nextRegDst      = ctrlPkg::DstRt;
        case (phase)
            ctrlPkg::FetchWait, ctrlPkg::FetchLatch: begin
                nextAluCtrl = ctrlPkg::AluAdd;  // PC + 4
                nextSrcB    = ctrlPkg::SrcBFour;
                if (phase == ctrlPkg::FetchLatch) begin
                    nextPcWrite     = 1'b1;
                    nextIrWrite     = 1'b1;
                    nextAluOutWrite = 1'b1;
                end
            end
            ctrlPkg::RegRead: nextAbWrite = 1'b1;
            ctrlPkg::ExecAlu, ctrlPkg::ExecWrite, ctrlPkg::ExecDone: begin
                nextAluCtrl = ctrlPkg::aluOpOf(op);
                nextSrcA    = ctrlPkg::SrcAReg;
                nextSrcB    = isAddi ? ctrlPkg::SrcBImm : ctrlPkg::SrcBReg;
                nextRegWrite = (phase == ctrlPkg::ExecWrite);
                // ADDI keeps the result register loaded through execute
                nextAluOutWrite = isAddi || (phase == ctrlPkg::ExecAlu);
                if (!isAddi && phase != ctrlPkg::ExecAlu) begin
                    nextRegDst = ctrlPkg::DstRd;  // R-type writes rd
                end
            end
            default: ;  // Decode, ResetHold, Halted
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcWrite     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b0;
            abWrite     <= 1'b0;
            aluOutWrite <= 1'b0;
            aluCtrl     <= ctrlPkg::AluNop;
            srcA        <= ctrlPkg::SrcAPc;
            srcB        <= ctrlPkg::SrcBReg;
            regDst      <= ctrlPkg::DstRt;
        end else begin
            pcWrite     <= nextPcWrite;
            irWrite     <= nextIrWrite;
            regWrite    <= nextRegWrite;
            abWrite     <= nextAbWrite;
            aluOutWrite <= nextAluOutWrite;
            aluCtrl     <= nextAluCtrl;
            srcA        <= nextSrcA;
            srcB        <= nextSrcB;
            regDst      <= nextRegDst;
        end
    end

    assert property (@(posedge clk) disable iff (reset) pcWrite |-> irWrite)
    else $error("controlEncoder: pcWrite without irWrite");

    assert property (@(posedge clk) disable iff (reset) !(regWrite && pcWrite))
    else $error("controlEncoder: regWrite and pcWrite together");

endmodule

`default_nettype wire

/* rtl/ctrlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlUnit #(
    parameter int MemWaitCycles = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  isaPkg::opcodeT   opcode,
    input  isaPkg::functT    funct,
    output logic             pcWrite,
    output logic             irWrite,
    output logic             regWrite,
    output logic             abWrite,
    output logic             aluOutWrite,
    output ctrlPkg::aluOpT   aluCtrl,
    output ctrlPkg::srcAT    srcA,
    output ctrlPkg::srcBT    srcB,
    output ctrlPkg::regDstT  regDst,
    output logic             resetOut
);

    ctrlPkg::phaseT phase;
    ctrlPkg::opT    op;
    logic           halt;

    instrDecoder decoder (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .phase  (phase),
        .op     (op),
        .halt   (halt)
    );

    phaseSequencer #(
        .MemWaitCycles (MemWaitCycles)
    ) sequencer (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .halt     (halt),
        .phase    (phase),
        .resetOut (resetOut)
    );

    // Control word lags phase by one cycle
    controlEncoder encoder (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .op          (op),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .abWrite     (abWrite),
        .aluOutWrite (aluOutWrite),
        .aluCtrl     (aluCtrl),
        .srcA        (srcA),
        .srcB        (srcB),
        .regDst      (regDst)
    );

endmodule

`default_nettype wire

/* include/ctrlRefModel.svh */
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// Expected outputs for one cycle of an instruction
typedef struct packed {
    logic            pcWrite;
    logic            irWrite;
    logic            regWrite;
    logic            abWrite;
    logic            aluOutWrite;
    ctrlPkg::aluOpT  aluCtrl;
    ctrlPkg::srcAT   srcA;
    ctrlPkg::srcBT   srcB;
    ctrlPkg::regDstT regDst;
    logic            resetOut;
    int              instrLen;  // Cycles until the next instruction starts
} ctrlWordT;

// cycle counts from 0 at the first FetchWait word of the instruction.
// A halt instruction never ends and every cycle past Decode gives the halted word.
function automatic ctrlWordT ctrlRefModel(input isaPkg::opcodeT opcode,
                                          input isaPkg::functT funct,
                                          input int cycle,
                                          input int memWait);
    ctrlWordT       w;
    ctrlPkg::aluOpT rAlu;
    logic           isR;
    logic           isAddi;
    logic           isHalt;
    int             fetchLen;
    int             rel;

    w        = '0;
    isHalt   = (opcode == isaPkg::ResetOp);
    isAddi   = (opcode == isaPkg::Addi);
    isR      = (opcode == isaPkg::RType) &&
               (funct inside {isaPkg::FnAdd, isaPkg::FnAnd, isaPkg::FnSub});
    rAlu     = (funct == isaPkg::FnSub) ? ctrlPkg::AluSub :
               (funct == isaPkg::FnAnd) ? ctrlPkg::AluAnd : ctrlPkg::AluAdd;
    fetchLen = memWait + 3;
    w.instrLen = (isR || isAddi) ? fetchLen + 3 : fetchLen;

    if (cycle <= memWait) begin
        w.aluCtrl = ctrlPkg::AluAdd;
        w.srcB    = ctrlPkg::SrcBFour;
        if (cycle == memWait) begin  // Latch cycle
            w.pcWrite     = 1'b1;
            w.irWrite     = 1'b1;
            w.aluOutWrite = 1'b1;
        end
    end else if (cycle == memWait + 1) begin
        w.abWrite = 1'b1;
    end else if (isHalt) begin
        w.resetOut = 1'b1;  // Rises together with the Decode word
    end else if (cycle >= fetchLen && (isR || isAddi)) begin
        rel           = cycle - fetchLen;
        w.aluCtrl     = isAddi ? ctrlPkg::AluAdd : rAlu;
        w.srcA        = ctrlPkg::SrcAReg;
        w.srcB        = isAddi ? ctrlPkg::SrcBImm : ctrlPkg::SrcBReg;
        w.regWrite    = (rel == 1);
        w.aluOutWrite = isAddi || (rel == 0);
        w.regDst      = (isR && rel > 0) ? ctrlPkg::DstRd : ctrlPkg::DstRt;
    end
    return w;
endfunction

`endif

/* test/ctrlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlUnitTb;

    localparam int MemWait     = 3;
    localparam int ClkPeriod   = 8;
    localparam int NumRandom   = 200;
    localparam int DirectCycles = 120;  // Bound on the directed tests and resets
    localparam int WatchdogNs  = (NumRandom * (MemWait + 6) + DirectCycles) * ClkPeriod + 800;

    logic            clk;
    logic            reset;
    isaPkg::opcodeT  opcode;
    isaPkg::functT   funct;
    logic            pcWrite;
    logic            irWrite;
    logic            regWrite;
    logic            abWrite;
    logic            aluOutWrite;
    ctrlPkg::aluOpT  aluCtrl;
    ctrlPkg::srcAT   srcA;
    ctrlPkg::srcBT   srcB;
    ctrlPkg::regDstT regDst;
    logic            resetOut;

    `include "ctrlRefModel.svh"

    ctrlWordT    expWord;
    logic        checkEn;
    int          errCount;
    int          checkCount;
    int          testNum;
    int          failedTests;
    int          errAtStart;
    string       testName;
    logic [31:0] rng;

    ctrlUnit #(
        .MemWaitCycles (MemWait)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .abWrite     (abWrite),
        .aluOutWrite (aluOutWrite),
        .aluCtrl     (aluCtrl),
        .srcA        (srcA),
        .srcB        (srcB),
        .regDst      (regDst),
        .resetOut    (resetOut)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compareField(input string name, input int expVal, input int actVal);
        checkCount++;
        if (expVal != actVal) begin
            errCount++;
            $display("Error at %0d ns: %s expected %0d got %0d", $time, name, expVal, actVal);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checkEn) begin
            compareField("pcWrite", int'(expWord.pcWrite), int'(pcWrite));
            compareField("irWrite", int'(expWord.irWrite), int'(irWrite));
            compareField("regWrite", int'(expWord.regWrite), int'(regWrite));
            compareField("abWrite", int'(expWord.abWrite), int'(abWrite));
            compareField("aluOutWrite", int'(expWord.aluOutWrite), int'(aluOutWrite));
            compareField("aluCtrl", int'(expWord.aluCtrl), int'(aluCtrl));
            compareField("srcA", int'(expWord.srcA), int'(srcA));
            compareField("srcB", int'(expWord.srcB), int'(srcB));
            compareField("regDst", int'(expWord.regDst), int'(regDst));
            compareField("resetOut", int'(expWord.resetOut), int'(resetOut));
        end
    end

    task automatic startTest(input string name);
        testNum++;
        testName   = name;
        errAtStart = errCount;
    endtask

    task automatic finishTest();
        int errs;
        errs = errCount - errAtStart;
        if (errs != 0) begin
            failedTests++;
        end
        $display("Test %0d (%s) finished with %0d errors", testNum, testName, errs);
    endtask

    // Reset for a number of cycles and expect a quiet word for one cycle
    task automatic applyReset(input int cycles);
        checkEn = 1'b0;
        reset   = 1'b1;
        repeat (cycles) @(posedge clk);
        #1;
        reset   = 1'b0;
        expWord = '0;
        checkEn = 1'b1;
        @(posedge clk);
        #1;
    endtask

    // Entered 1 ns after the edge that shows cycle 0 of this instruction
    task automatic runInstr(input isaPkg::opcodeT opc, input isaPkg::functT fn, input int extra);
        ctrlWordT first;
        int       len;
        int       c;
        first  = ctrlRefModel(opc, fn, 0, MemWait);
        len    = first.instrLen + extra;
        opcode = opc;
        funct  = fn;
        for (c = 0; c < len; c++) begin
            expWord = ctrlRefModel(opc, fn, c, MemWait);
            checkEn = 1'b1;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runRandomStream(input int count);
        logic [2:0] sel;
        logic [5:0] opBits;
        logic [5:0] fnBits;
        int         i;
        for (i = 0; i < count; i++) begin
            rng    = xorshift32(rng);
            sel    = rng[2:0];
            opBits = rng[13:8];
            fnBits = rng[21:16];
            if (opBits == 6'h00 || opBits == 6'h08 || opBits == 6'h3f) begin
                opBits = 6'h23;  // Load word is not implemented
            end
            case (sel)
                3'd0: runInstr(isaPkg::RType, isaPkg::FnAdd, 0);
                3'd1: runInstr(isaPkg::RType, isaPkg::FnAnd, 0);
                3'd2: runInstr(isaPkg::RType, isaPkg::FnSub, 0);
                3'd3, 3'd4: runInstr(isaPkg::Addi, isaPkg::functT'(fnBits), 0);
                3'd5: runInstr(isaPkg::opcodeT'(opBits), isaPkg::functT'(fnBits), 0);
                default: runInstr(isaPkg::RType, isaPkg::functT'(fnBits), 0);  // Any funct
            endcase
        end
    endtask

    initial begin
        reset       = 1'b1;
        opcode      = isaPkg::RType;
        funct       = isaPkg::FnAdd;
        checkEn     = 1'b0;
        expWord     = '0;
        errCount    = 0;
        checkCount  = 0;
        testNum     = 0;
        failedTests = 0;
        errAtStart  = 0;
        rng         = 32'd67263;

        startTest("reset then fetch");
        applyReset(4);
        finishTest();

        startTest("unknown opcode and funct");
        runInstr(isaPkg::opcodeT'(6'h23), isaPkg::FnAdd, 0);
        runInstr(isaPkg::RType, isaPkg::functT'(6'h25), 0);
        finishTest();

        startTest("R-type ADD AND SUB");
        runInstr(isaPkg::RType, isaPkg::FnAdd, 0);
        runInstr(isaPkg::RType, isaPkg::FnAnd, 0);
        runInstr(isaPkg::RType, isaPkg::FnSub, 0);
        finishTest();

        startTest("ADDI");
        runInstr(isaPkg::Addi, isaPkg::functT'(6'h11), 0);
        finishTest();

        startTest("halt and 4-cycle reset");
        runInstr(isaPkg::ResetOp, isaPkg::FnAdd, 4);  // Stays halted
        applyReset(4);
        runInstr(isaPkg::RType, isaPkg::FnSub, 0);
        finishTest();

        startTest("random stream");
        runRandomStream(NumRandom);
        finishTest();

        startTest("one-cycle reset hold");
        checkEn = 1'b0;
        reset   = 1'b1;
        @(posedge clk);
        #1;
        reset            = 1'b0;
        expWord          = '0;
        expWord.resetOut = 1'b1;
        checkEn          = 1'b1;
        repeat (6) begin
            @(posedge clk);
            #1;
        end
        checkEn = 1'b0;
        finishTest();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 testNum, failedTests, checkCount, errCount);
        if (errCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* ctrlUnit.f */
+incdir+include
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/phaseSequencer.sv
rtl/controlEncoder.sv
rtl/ctrlUnit.sv
test/ctrlUnitTb.sv

/* runSim.sh */
#!/bin/sh
# Builds the ctrlUnit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ctrlUnitTb \
    -f ctrlUnit.f -o simv > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
